// ==== common/rv64_exec_defs.svh ====
`ifndef RV64_EXEC_DEFS_SVH
`define RV64_EXEC_DEFS_SVH

`define RV64_XLEN       64
`define RV64_REG_IDX_W  5
`define RV64_INFO_W     16
`define RV64_LS_INFO_W  7

// unit selector field
`define RV64_INFO_UNIT_W    3
`define RV64_INFO_UNIT_MSB  2
`define RV64_INFO_UNIT_LSB  0

// alu op bits
`define RV64_INFO_ALU_WOP     3
`define RV64_INFO_ALU_ADD     4
`define RV64_INFO_ALU_SUB     5
`define RV64_INFO_ALU_SLL     6
`define RV64_INFO_ALU_SRL     7
`define RV64_INFO_ALU_SRA     8
`define RV64_INFO_ALU_SLT     9
`define RV64_INFO_ALU_SLTU    10
`define RV64_INFO_ALU_XOR     11
`define RV64_INFO_ALU_OR      12
`define RV64_INFO_ALU_AND     13
`define RV64_INFO_ALU_LUI     14
`define RV64_INFO_ALU_EBREAK  15

// branch / jump bits
`define RV64_INFO_BJP_JAL   3
`define RV64_INFO_BJP_JALR  4
`define RV64_INFO_BJP_BEQ   5
`define RV64_INFO_BJP_BNE   6
`define RV64_INFO_BJP_BLT   7
`define RV64_INFO_BJP_BGE   8
`define RV64_INFO_BJP_BLTU  9
`define RV64_INFO_BJP_BGEU  10

// load / store bits
`define RV64_INFO_LS_LOAD   3
`define RV64_INFO_LS_STORE  4
`define RV64_INFO_LS_USIGN  5
`define RV64_INFO_LS_BYTE   6
`define RV64_INFO_LS_HALF   7
`define RV64_INFO_LS_WORD   8
`define RV64_INFO_LS_DWORD  9

`endif

// ==== common/rv_types_pkg.sv ====
`include "rv64_exec_defs.svh"

package rv_types_pkg;

  // full register / data word
  typedef logic [`RV64_XLEN-1:0] xlen_t;

  // architectural register index
  typedef logic [`RV64_REG_IDX_W-1:0] reg_idx_t;

  // shift amount, enough bits to cover xlen
  typedef logic [$clog2(`RV64_XLEN)-1:0] shamt_t;

endpackage

// ==== common/exu_ctrl_pkg.sv ====
`include "rv64_exec_defs.svh"

package exu_ctrl_pkg;

  // decoded execute-info word from the decoder
  typedef logic [`RV64_INFO_W-1:0] exu_info_t;

  // unit selector in info bits 2:0
  typedef enum logic [`RV64_INFO_UNIT_W-1:0] {
    EXU_NONE = 3'd0,
    EXU_ALU  = 3'd1,
    EXU_BJP  = 3'd2,
    EXU_LS   = 3'd3
  } exu_unit_e;

  // load/store info handed to the memory stage
  // bit 0 load, 1 store, 2 unsigned, 3 byte, 4 half, 5 word, 6 dword
  typedef logic [`RV64_LS_INFO_W-1:0] ls_info_t;

endpackage

// ==== exu/exu_alu.sv ====
`timescale 1ns/1ps
`include "rv64_exec_defs.svh"

module exu_alu
  import rv_types_pkg::*;
  import exu_ctrl_pkg::*;
(
  input  xlen_t     op1_i,
  input  xlen_t     op2_i,
  input  exu_info_t info_i,
  input  logic      alu_sel_i,
  input  logic      sub_sel_i,
  output xlen_t     alu_res_o,
  output xlen_t     sum_o,
  output logic      carry_o
);

  xlen_t  adder_in2;
  xlen_t  adder_sum;
  logic   adder_cout;
  shamt_t shamt;
  logic   op1_sign;
  logic   op2_sign;
  logic   lt_signed;
  logic   lt_unsigned;

  logic op_wop;
  logic op_add_sub;
  logic op_full;
  logic op_word;
  logic op_sll;
  logic op_srl;
  logic op_sra;
  logic op_slt;
  logic op_sltu;
  logic op_xor;
  logic op_or;
  logic op_and;
  logic op_lui;

  xlen_t word_res;
  xlen_t sll_res;
  xlen_t srl_res;
  xlen_t sra_res;

  // single adder, subtract as op1 + ~op2 + 1
  assign adder_in2 = sub_sel_i ? ~op2_i : op2_i;
  assign {adder_cout, adder_sum} = {1'b0, op1_i} + {1'b0, adder_in2} +
                                   {{`RV64_XLEN{1'b0}}, sub_sel_i};

  assign sum_o   = adder_sum;
  assign carry_o = adder_cout;

  // op selects, only meaningful for alu instructions
  assign op_wop     = alu_sel_i & info_i[`RV64_INFO_ALU_WOP];
  assign op_add_sub = alu_sel_i & (info_i[`RV64_INFO_ALU_ADD] | info_i[`RV64_INFO_ALU_SUB]);
  assign op_full    = op_add_sub & ~op_wop;
  assign op_word    = op_add_sub & op_wop;
  assign op_sll     = alu_sel_i & info_i[`RV64_INFO_ALU_SLL];
  assign op_srl     = alu_sel_i & info_i[`RV64_INFO_ALU_SRL];
  assign op_sra     = alu_sel_i & info_i[`RV64_INFO_ALU_SRA];
  assign op_slt     = alu_sel_i & info_i[`RV64_INFO_ALU_SLT];
  assign op_sltu    = alu_sel_i & info_i[`RV64_INFO_ALU_SLTU];
  assign op_xor     = alu_sel_i & info_i[`RV64_INFO_ALU_XOR];
  assign op_or      = alu_sel_i & info_i[`RV64_INFO_ALU_OR];
  assign op_and     = alu_sel_i & info_i[`RV64_INFO_ALU_AND];
  assign op_lui     = alu_sel_i & info_i[`RV64_INFO_ALU_LUI];

  // addw/subw keep the low word, sign-extend bit 31
  assign word_res = {{(`RV64_XLEN-32){adder_sum[31]}}, adder_sum[31:0]};

  assign shamt   = op2_i[$bits(shamt_t)-1:0];
  assign sll_res = op1_i << shamt;
  assign srl_res = op1_i >> shamt;
  assign sra_res = xlen_t'($signed(op1_i) >>> shamt);

  // compares from the subtract result
  assign op1_sign    = op1_i[`RV64_XLEN-1];
  assign op2_sign    = op2_i[`RV64_XLEN-1];
  assign lt_signed   = (op1_sign & ~op2_sign) |
                       (~(op1_sign ^ op2_sign) & adder_sum[`RV64_XLEN-1]);
  assign lt_unsigned = ~adder_cout;

  assign alu_res_o = ({`RV64_XLEN{op_full}} & adder_sum)          |
                     ({`RV64_XLEN{op_word}} & word_res)           |
                     ({`RV64_XLEN{op_sll}}  & sll_res)            |
                     ({`RV64_XLEN{op_srl}}  & srl_res)            |
                     ({`RV64_XLEN{op_sra}}  & sra_res)            |
                     ({`RV64_XLEN{op_slt}}  & xlen_t'(lt_signed))   |
                     ({`RV64_XLEN{op_sltu}} & xlen_t'(lt_unsigned)) |
                     ({`RV64_XLEN{op_xor}}  & (op1_i ^ op2_i))    |
                     ({`RV64_XLEN{op_or}}   & (op1_i | op2_i))    |
                     ({`RV64_XLEN{op_and}}  & (op1_i & op2_i))    |
                     ({`RV64_XLEN{op_lui}}  & op2_i);

endmodule

// ==== exu/exu_branch.sv ====
`timescale 1ns/1ps
`include "rv64_exec_defs.svh"

module exu_branch
  import rv_types_pkg::*;
  import exu_ctrl_pkg::*;
(
  input  logic      op1_sign_i,
  input  logic      op2_sign_i,
  input  xlen_t     sum_i,
  input  logic      carry_i,
  input  logic      bjp_sel_i,
  input  exu_info_t info_i,
  input  xlen_t     jp_base_i,
  input  xlen_t     jp_off_i,
  output logic      jump_taken_o,
  output xlen_t     jump_addr_o
);

  logic cmp_eq;
  logic cmp_lt;
  logic cmp_ltu;
  logic uncond;
  logic cond_hit;

  // adder was set to op1 - op2 for conditional branches
  assign cmp_eq  = ~|sum_i;
  assign cmp_lt  = (op1_sign_i & ~op2_sign_i) |
                   (~(op1_sign_i ^ op2_sign_i) & sum_i[`RV64_XLEN-1]);
  assign cmp_ltu = ~carry_i;

  assign uncond = info_i[`RV64_INFO_BJP_JAL] | info_i[`RV64_INFO_BJP_JALR];

  assign cond_hit = (info_i[`RV64_INFO_BJP_BEQ]  &  cmp_eq)  |
                    (info_i[`RV64_INFO_BJP_BNE]  & ~cmp_eq)  |
                    (info_i[`RV64_INFO_BJP_BLT]  &  cmp_lt)  |
                    (info_i[`RV64_INFO_BJP_BGE]  & ~cmp_lt)  |
                    (info_i[`RV64_INFO_BJP_BLTU] &  cmp_ltu) |
                    (info_i[`RV64_INFO_BJP_BGEU] & ~cmp_ltu);

  assign jump_taken_o = bjp_sel_i & (uncond | cond_hit);

  // separate target adder, base is pc or rs1
  assign jump_addr_o = jp_base_i + jp_off_i;

endmodule

// ==== exu/exec_unit.sv ====
`timescale 1ns/1ps
`include "rv64_exec_defs.svh"

module exec_unit
  import rv_types_pkg::*;
  import exu_ctrl_pkg::*;
(
  input  xlen_t     op1_i,
  input  xlen_t     op2_i,
  input  xlen_t     jp_base_i,
  input  xlen_t     jp_off_store_i,
  input  exu_info_t info_i,
  output xlen_t     alu_res_o,
  output ls_info_t  ls_info_o,
  output xlen_t     store_data_o,
  output logic      jump_taken_o,
  output xlen_t     jump_addr_o,
  output logic      ebreak_o
);

  exu_unit_e unit;
  logic      alu_sel;
  logic      bjp_sel;
  logic      ls_sel;
  logic      sub_sel;
  logic      force_add;
  logic      op_store;
  xlen_t     alu_res;
  xlen_t     sum;
  logic      carry;

  assign unit = exu_unit_e'(info_i[`RV64_INFO_UNIT_MSB:`RV64_INFO_UNIT_LSB]);

  always_comb begin
    alu_sel = 1'b0;
    bjp_sel = 1'b0;
    ls_sel  = 1'b0;
    case (unit)
      EXU_ALU: alu_sel = 1'b1;
      EXU_BJP: bjp_sel = 1'b1;
      EXU_LS:  ls_sel  = 1'b1;
      // bubble or unknown selector, no unit active
      default: begin
      end
    endcase
  end

  // subtract for compares and conditional branches
  assign sub_sel = (alu_sel & (info_i[`RV64_INFO_ALU_SUB] | info_i[`RV64_INFO_ALU_SLT] |
                               info_i[`RV64_INFO_ALU_SLTU])) |
                   (bjp_sel & (info_i[`RV64_INFO_BJP_BEQ]  | info_i[`RV64_INFO_BJP_BNE] |
                               info_i[`RV64_INFO_BJP_BLT]  | info_i[`RV64_INFO_BJP_BGE] |
                               info_i[`RV64_INFO_BJP_BLTU] | info_i[`RV64_INFO_BJP_BGEU]));

  // link value for jal/jalr, effective address for load/store
  assign force_add = ls_sel |
                     (bjp_sel & (info_i[`RV64_INFO_BJP_JAL] | info_i[`RV64_INFO_BJP_JALR]));

  exu_alu u_alu (
    .op1_i     (op1_i),
    .op2_i     (op2_i),
    .info_i    (info_i),
    .alu_sel_i (alu_sel),
    .sub_sel_i (sub_sel),
    .alu_res_o (alu_res),
    .sum_o     (sum),
    .carry_o   (carry)
  );

  exu_branch u_branch (
    .op1_sign_i   (op1_i[`RV64_XLEN-1]),
    .op2_sign_i   (op2_i[`RV64_XLEN-1]),
    .sum_i        (sum),
    .carry_i      (carry),
    .bjp_sel_i    (bjp_sel),
    .info_i       (info_i),
    .jp_base_i    (jp_base_i),
    .jp_off_i     (jp_off_store_i),
    .jump_taken_o (jump_taken_o),
    .jump_addr_o  (jump_addr_o)
  );

  assign alu_res_o = alu_res | ({`RV64_XLEN{force_add}} & sum);

  assign op_store  = ls_sel & info_i[`RV64_INFO_LS_STORE];
  assign ls_info_o = {`RV64_LS_INFO_W{ls_sel}} &
                     {info_i[`RV64_INFO_LS_DWORD], info_i[`RV64_INFO_LS_WORD],
                      info_i[`RV64_INFO_LS_HALF],  info_i[`RV64_INFO_LS_BYTE],
                      info_i[`RV64_INFO_LS_USIGN], info_i[`RV64_INFO_LS_STORE],
                      info_i[`RV64_INFO_LS_LOAD]};

  // rs2 value shares the jump offset port
  assign store_data_o = op_store ? jp_off_store_i : '0;

  assign ebreak_o = alu_sel & info_i[`RV64_INFO_ALU_EBREAK];

endmodule

// ==== source/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg
  import rv_types_pkg::*;
  import exu_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     valid_i,
  input  logic     rd_wr_en_i,
  input  reg_idx_t rd_idx_i,
  input  logic     illegal_i,
  input  xlen_t    alu_res_i,
  input  ls_info_t ls_info_i,
  input  xlen_t    store_data_i,
  input  logic     jump_taken_i,
  input  xlen_t    jump_addr_i,
  input  logic     ebreak_i,
  output logic     mem_valid_o,
  output logic     mem_rd_wr_en_o,
  output reg_idx_t mem_rd_idx_o,
  output xlen_t    mem_alu_res_o,
  output ls_info_t mem_ls_info_o,
  output xlen_t    mem_store_data_o,
  output logic     jump_o,
  output xlen_t    jump_addr_o,
  output logic     halt_o,
  output logic     illegal_o
);

  logic slot_valid;

  // branch shadow, drop the slot right after a taken jump
  assign slot_valid = valid_i & ~jump_o;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mem_valid_o    <= 1'b0;
      mem_rd_wr_en_o <= 1'b0;
      mem_ls_info_o  <= '0;
      jump_o         <= 1'b0;
      halt_o         <= 1'b0;
      illegal_o      <= 1'b0;
    end else begin
      mem_valid_o    <= slot_valid;
      mem_rd_wr_en_o <= slot_valid & rd_wr_en_i;
      mem_ls_info_o  <= {$bits(ls_info_t){slot_valid}} & ls_info_i;
      jump_o         <= slot_valid & jump_taken_i;
      halt_o         <= slot_valid & ebreak_i;
      illegal_o      <= slot_valid & illegal_i;
    end
  end

  // payload, qualified by mem_valid_o downstream
  always_ff @(posedge clk) begin
    mem_rd_idx_o     <= rd_idx_i;
    mem_alu_res_o    <= alu_res_i;
    mem_store_data_o <= store_data_i;
    jump_addr_o      <= jump_addr_i;
  end

endmodule

// ==== source/exec_stage_top.sv ====
`timescale 1ns/1ps

module exec_stage_top
  import rv_types_pkg::*;
  import exu_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      valid_i,
  input  xlen_t     op1_i,
  input  xlen_t     op2_i,
  input  xlen_t     jp_base_i,
  input  xlen_t     jp_off_store_i,
  input  exu_info_t info_i,
  input  logic      rd_wr_en_i,
  input  reg_idx_t  rd_idx_i,
  input  logic      illegal_i,
  output logic      mem_valid_o,
  output logic      mem_rd_wr_en_o,
  output reg_idx_t  mem_rd_idx_o,
  output xlen_t     mem_alu_res_o,
  output ls_info_t  mem_ls_info_o,
  output xlen_t     mem_store_data_o,
  output logic      jump_o,
  output xlen_t     jump_addr_o,
  output logic      halt_o,
  output logic      illegal_o
);

  xlen_t    alu_res;
  ls_info_t ls_info;
  xlen_t    store_data;
  logic     jump_taken;
  xlen_t    jump_addr;
  logic     ebreak;

  exec_unit u_exec_unit (
    .op1_i          (op1_i),
    .op2_i          (op2_i),
    .jp_base_i      (jp_base_i),
    .jp_off_store_i (jp_off_store_i),
    .info_i         (info_i),
    .alu_res_o      (alu_res),
    .ls_info_o      (ls_info),
    .store_data_o   (store_data),
    .jump_taken_o   (jump_taken),
    .jump_addr_o    (jump_addr),
    .ebreak_o       (ebreak)
  );

  ex_mem_reg u_ex_mem_reg (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .valid_i          (valid_i),
    .rd_wr_en_i       (rd_wr_en_i),
    .rd_idx_i         (rd_idx_i),
    .illegal_i        (illegal_i),
    .alu_res_i        (alu_res),
    .ls_info_i        (ls_info),
    .store_data_i     (store_data),
    .jump_taken_i     (jump_taken),
    .jump_addr_i      (jump_addr),
    .ebreak_i         (ebreak),
    .mem_valid_o      (mem_valid_o),
    .mem_rd_wr_en_o   (mem_rd_wr_en_o),
    .mem_rd_idx_o     (mem_rd_idx_o),
    .mem_alu_res_o    (mem_alu_res_o),
    .mem_ls_info_o    (mem_ls_info_o),
    .mem_store_data_o (mem_store_data_o),
    .jump_o           (jump_o),
    .jump_addr_o      (jump_addr_o),
    .halt_o           (halt_o),
    .illegal_o        (illegal_o)
  );

endmodule

// ==== sim/exec_stage_properties.sv ====
`timescale 1ns/1ps

module exec_stage_props
  import exu_ctrl_pkg::*;
(
  input logic     clk,
  input logic     rst_n_i,
  input logic     mem_valid_o,
  input logic     mem_rd_wr_en_o,
  input ls_info_t mem_ls_info_o,
  input logic     jump_o,
  input logic     halt_o,
  input logic     illegal_o
);

  // read by the testbench at the end of the run
  int assert_fail_cnt = 0;

  // an empty slot carries no strobes
  a_idle_no_strobes: assert property (@(posedge clk) disable iff (!rst_n_i)
    !mem_valid_o |-> !(mem_rd_wr_en_o | jump_o | halt_o | illegal_o | (|mem_ls_info_o)))
  else begin
    assert_fail_cnt++;
    $error("strobe active in an empty slot");
  end

  // branch shadow slot is squashed
  a_shadow_squash: assert property (@(posedge clk) disable iff (!rst_n_i)
    jump_o |=> !mem_valid_o)
  else begin
    assert_fail_cnt++;
    $error("slot after a taken jump is still valid");
  end

  a_halt_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(halt_o) |-> mem_valid_o)
  else begin
    assert_fail_cnt++;
    $error("halt rose without a valid slot");
  end

  a_illegal_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(illegal_o) |-> mem_valid_o)
  else begin
    assert_fail_cnt++;
    $error("illegal rose without a valid slot");
  end

endmodule

// ==== sim/exec_stage_tb.sv ====
`timescale 1ns/1ps
`include "rv64_exec_defs.svh"

module exec_stage_tb
  import rv_types_pkg::*;
  import exu_ctrl_pkg::*;
;

  localparam int IDLE_N = 4;
  localparam int ALU_N = 200;
  localparam int BJP_N = 64;
  localparam int LS_N = 16;
  localparam int SHADOW_N = 3;
  localparam int FLAG_N = 3;
  localparam int ISSUE_TOTAL = 2 * IDLE_N + ALU_N + BJP_N + LS_N + SHADOW_N + FLAG_N;
  localparam int TIMEOUT_CYCLES = 2 * ISSUE_TOTAL + 20;

  logic      clk = 1'b0;
  logic      rst_n_i;
  logic      valid_i;
  xlen_t     op1_i;
  xlen_t     op2_i;
  xlen_t     jp_base_i;
  xlen_t     jp_off_store_i;
  exu_info_t info_i;
  logic      rd_wr_en_i;
  reg_idx_t  rd_idx_i;
  logic      illegal_i;
  logic      mem_valid_o;
  logic      mem_rd_wr_en_o;
  reg_idx_t  mem_rd_idx_o;
  xlen_t     mem_alu_res_o;
  ls_info_t  mem_ls_info_o;
  xlen_t     mem_store_data_o;
  logic      jump_o;
  xlen_t     jump_addr_o;
  logic      halt_o;
  logic      illegal_o;

  integer seed = 32'h9934;
  int     checked_cnt = 0;

  // issued slots waiting for their compare
  logic      q_valid[$];
  logic      q_wr[$];
  logic      q_ill[$];
  reg_idx_t  q_idx[$];
  exu_info_t q_info[$];
  xlen_t     q_op1[$];
  xlen_t     q_op2[$];
  xlen_t     q_base[$];
  xlen_t     q_off[$];

  always #2 clk = ~clk;

  exec_stage_top DUT (.*);

  bind exec_stage_top exec_stage_props u_props (.*);

  task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic check_ls_info(input string name, input ls_info_t exp, input ls_info_t act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic check_reg_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // expected execute results, straight from the instruction semantics
  function automatic void ref_exec(
    input  xlen_t     a,
    input  xlen_t     b,
    input  xlen_t     base,
    input  xlen_t     off,
    input  exu_info_t info,
    output xlen_t     res,
    output ls_info_t  ls,
    output xlen_t     st,
    output logic      jmp,
    output xlen_t     jaddr,
    output logic      ebrk
  );
    logic signed [`RV64_XLEN-1:0] sa;
    logic signed [`RV64_XLEN-1:0] sb;
    logic [31:0] w;
    shamt_t sh;
    sa = a;
    sb = b;
    sh = shamt_t'(b);
    res = '0;
    ls = '0;
    st = '0;
    jmp = 1'b0;
    ebrk = 1'b0;
    jaddr = base + off;
    case (info[2:0])
      EXU_ALU: begin
        w = info[`RV64_INFO_ALU_SUB] ? (a[31:0] - b[31:0]) : (a[31:0] + b[31:0]);
        if (info[`RV64_INFO_ALU_WOP]) res = {{32{w[31]}}, w};
        else if (info[`RV64_INFO_ALU_ADD]) res = a + b;
        else if (info[`RV64_INFO_ALU_SUB]) res = a - b;
        else if (info[`RV64_INFO_ALU_SLL]) res = a << sh;
        else if (info[`RV64_INFO_ALU_SRL]) res = a >> sh;
        else if (info[`RV64_INFO_ALU_SRA]) res = sa >>> sh;
        else if (info[`RV64_INFO_ALU_SLT]) res = xlen_t'(sa < sb);
        else if (info[`RV64_INFO_ALU_SLTU]) res = xlen_t'(a < b);
        else if (info[`RV64_INFO_ALU_XOR]) res = a ^ b;
        else if (info[`RV64_INFO_ALU_OR]) res = a | b;
        else if (info[`RV64_INFO_ALU_AND]) res = a & b;
        else if (info[`RV64_INFO_ALU_LUI]) res = b;
        ebrk = info[`RV64_INFO_ALU_EBREAK];
      end
      EXU_BJP: begin
        jmp = info[`RV64_INFO_BJP_JAL] | info[`RV64_INFO_BJP_JALR] |
              (info[`RV64_INFO_BJP_BEQ] & (a == b)) | (info[`RV64_INFO_BJP_BNE] & (a != b)) |
              (info[`RV64_INFO_BJP_BLT] & (sa < sb)) | (info[`RV64_INFO_BJP_BGE] & (sa >= sb)) |
              (info[`RV64_INFO_BJP_BLTU] & (a < b)) | (info[`RV64_INFO_BJP_BGEU] & (a >= b));
        // link base sum for jal/jalr
        if (info[`RV64_INFO_BJP_JAL] | info[`RV64_INFO_BJP_JALR]) res = a + b;
      end
      EXU_LS: begin
        res = a + b;
        ls = {info[`RV64_INFO_LS_DWORD], info[`RV64_INFO_LS_WORD], info[`RV64_INFO_LS_HALF],
              info[`RV64_INFO_LS_BYTE], info[`RV64_INFO_LS_USIGN], info[`RV64_INFO_LS_STORE],
              info[`RV64_INFO_LS_LOAD]};
        if (info[`RV64_INFO_LS_STORE]) st = off;
      end
      default: begin
      end
    endcase
  endfunction

  function automatic xlen_t rand_xlen();
    return {$random(seed), $random(seed)};
  endfunction

  // corner values mixed into random operands
  function automatic xlen_t pick_operand();
    case ($unsigned($random(seed)) % 8)
      0: return {1'b1, {(`RV64_XLEN-1){1'b0}}};
      1: return '0;
      2: return '1;
      3: return {1'b0, {(`RV64_XLEN-1){1'b1}}};
      default: return rand_xlen();
    endcase
  endfunction

  // drive one slot on the falling edge, queue it once accepted
  task automatic issue(input logic v, input logic wr, input reg_idx_t idx, input logic ill,
                       input exu_info_t info, input xlen_t a, input xlen_t b);
    xlen_t base;
    xlen_t off;
    base = rand_xlen();
    off = rand_xlen();
    @(negedge clk);
    valid_i = v;
    rd_wr_en_i = wr;
    rd_idx_i = idx;
    illegal_i = ill;
    info_i = info;
    op1_i = a;
    op2_i = b;
    jp_base_i = base;
    jp_off_store_i = off;
    @(posedge clk);
    q_valid.push_back(v);
    q_wr.push_back(wr);
    q_idx.push_back(idx);
    q_ill.push_back(ill);
    q_info.push_back(info);
    q_op1.push_back(a);
    q_op2.push_back(b);
    q_base.push_back(base);
    q_off.push_back(off);
  endtask

  function automatic exu_info_t make_info(input exu_unit_e unit, input int bit_pos);
    exu_info_t info;
    info = '0;
    info[2:0] = unit;
    info[bit_pos] = 1'b1;
    return info;
  endfunction

  initial begin : compare_proc
    logic      v;
    logic      wr;
    logic      ill;
    logic      eff_valid;
    logic      prev_jump;
    logic      jmp;
    logic      ebrk;
    reg_idx_t  idx;
    exu_info_t info;
    xlen_t     a;
    xlen_t     b;
    xlen_t     base;
    xlen_t     off;
    xlen_t     res;
    xlen_t     st;
    xlen_t     jaddr;
    ls_info_t  ls;
    prev_jump = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (q_valid.size() > 0) begin
        v = q_valid.pop_front();
        wr = q_wr.pop_front();
        idx = q_idx.pop_front();
        ill = q_ill.pop_front();
        info = q_info.pop_front();
        a = q_op1.pop_front();
        b = q_op2.pop_front();
        base = q_base.pop_front();
        off = q_off.pop_front();
        ref_exec(a, b, base, off, info, res, ls, st, jmp, jaddr, ebrk);
        eff_valid = v & ~prev_jump;
        check_flag("mem_valid_o", eff_valid, mem_valid_o);
        check_flag("mem_rd_wr_en_o", eff_valid & wr, mem_rd_wr_en_o);
        check_ls_info("mem_ls_info_o", eff_valid ? ls : '0, mem_ls_info_o);
        check_flag("jump_o", eff_valid & jmp, jump_o);
        check_flag("halt_o", eff_valid & ebrk, halt_o);
        check_flag("illegal_o", eff_valid & ill, illegal_o);
        // data outputs only matter in a valid slot
        if (eff_valid) begin
          check_reg_idx("mem_rd_idx_o", idx, mem_rd_idx_o);
          check_xlen("mem_alu_res_o", res, mem_alu_res_o);
          check_xlen("mem_store_data_o", st, mem_store_data_o);
          check_xlen("jump_addr_o", jaddr, jump_addr_o);
        end
        prev_jump = eff_valid & jmp;
        checked_cnt++;
      end
    end
  end

  initial begin : watchdog
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  end

  initial begin : stimulus
    int        i;
    int        sel;
    exu_info_t info;
    xlen_t     a;
    rst_n_i = 1'b0;
    valid_i = 1'b0;
    rd_wr_en_i = 1'b0;
    rd_idx_i = '0;
    illegal_i = 1'b0;
    info_i = '0;
    op1_i = '0;
    op2_i = '0;
    jp_base_i = '0;
    jp_off_store_i = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;

    // idle slots with live looking inputs, each unit in turn
    for (i = 0; i < IDLE_N; i++) begin
      case (i % 3)
        0: info = make_info(EXU_ALU, `RV64_INFO_ALU_EBREAK);
        1: info = make_info(EXU_BJP, `RV64_INFO_BJP_JAL);
        default: begin
          info = make_info(EXU_LS, `RV64_INFO_LS_STORE);
          info[`RV64_INFO_LS_DWORD] = 1'b1;
        end
      endcase
      issue(1'b0, 1'b1, reg_idx_t'(i), 1'b1, info, '1, '1);
    end

    for (i = 0; i < ALU_N; i++) begin
      sel = $unsigned($random(seed)) % 13;
      // add..lui sit on consecutive bits, 11 and 12 are addw/subw
      if (sel < 11) begin
        info = make_info(EXU_ALU, `RV64_INFO_ALU_ADD + sel);
      end else begin
        info = make_info(EXU_ALU, `RV64_INFO_ALU_ADD + sel - 11);
        info[`RV64_INFO_ALU_WOP] = 1'b1;
      end
      issue(1'b1, 1'($random(seed)), reg_idx_t'($random(seed)), 1'b0, info,
            pick_operand(), pick_operand());
    end

    for (i = 0; i < BJP_N; i++) begin
      sel = $unsigned($random(seed)) % 8;
      a = pick_operand();
      info = make_info(EXU_BJP, `RV64_INFO_BJP_JAL + sel);
      issue(1'b1, sel < 2, reg_idx_t'($random(seed)), 1'b0, info, a,
            (($random(seed) & 3) == 0) ? a : pick_operand());
    end

    // every width as load and store, unsigned loads on the second pass
    for (i = 0; i < LS_N; i++) begin
      info = make_info(EXU_LS, `RV64_INFO_LS_BYTE + (i % 4));
      info[(i / 4) % 2 ? `RV64_INFO_LS_STORE : `RV64_INFO_LS_LOAD] = 1'b1;
      info[`RV64_INFO_LS_USIGN] = (i >= 8) && ((i / 4) % 2 == 0);
      issue(1'b1, (i / 4) % 2 == 0, reg_idx_t'(i), 1'b0, info, rand_xlen(), rand_xlen());
    end

    // taken jump, shadowed slot, then a valid slot again
    issue(1'b1, 1'b1, 5'd1, 1'b0, make_info(EXU_BJP, `RV64_INFO_BJP_JAL), rand_xlen(), 64'd4);
    issue(1'b1, 1'b1, 5'd2, 1'b0, make_info(EXU_ALU, `RV64_INFO_ALU_ADD), 64'd5, 64'd6);
    issue(1'b1, 1'b1, 5'd3, 1'b0, make_info(EXU_ALU, `RV64_INFO_ALU_ADD), 64'd7, 64'd8);

    issue(1'b1, 1'b1, 5'd7, 1'b0, make_info(EXU_ALU, `RV64_INFO_ALU_EBREAK), '0, '0);
    issue(1'b1, 1'b0, 5'd12, 1'b1, '0, '0, '0);
    issue(1'b1, 1'b1, 5'd31, 1'b0, make_info(EXU_ALU, `RV64_INFO_ALU_OR), 64'd1, 64'd2);

    for (i = 0; i < IDLE_N; i++) begin
      issue(1'b0, 1'b0, '0, 1'b0, '0, '0, '0);
    end
    @(negedge clk);
    valid_i = 1'b0;

    while (q_valid.size() > 0) begin
      @(posedge clk);
    end
    @(posedge clk);
    if (checked_cnt == ISSUE_TOTAL && DUT.u_props.assert_fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("compared %0d of %0d slots, %0d assertion failures", checked_cnt,
               ISSUE_TOTAL, DUT.u_props.assert_fail_cnt);
      $display("SOME TESTS FAILED");
      $fatal(1, "run incomplete");
    end
  end

endmodule

// ==== rv64_exec.f ====
+incdir+common
common/rv_types_pkg.sv
common/exu_ctrl_pkg.sv
exu/exu_alu.sv
exu/exu_branch.sv
exu/exec_unit.sv
source/ex_mem_reg.sv
source/exec_stage_top.sv
sim/exec_stage_properties.sv
sim/exec_stage_tb.sv

// ==== Bender.yml ====
package:
  name: rv64_exec

sources:
  - include_dirs:
      - common
    files:
      - common/rv_types_pkg.sv
      - common/exu_ctrl_pkg.sv
      - exu/exu_alu.sv
      - exu/exu_branch.sv
      - exu/exec_unit.sv
      - source/ex_mem_reg.sv
      - source/exec_stage_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/exec_stage_properties.sv
      - sim/exec_stage_tb.sv
